/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert --timing --timescale 1ns/1ps
TOP      = tb_top_board
FILELIST = tb.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "test FAILED"; exit 1; fi
	@if ! grep -q "Simulation passed" $(LOG); then echo "test FAILED"; exit 1; fi
	@echo "test PASSED"

clean:
	rm -rf $(BUILD) $(LOG)

/* tb.f */
verilog/mips_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/mips_core.sv
verilog/debug_unit.sv
verilog/top_board.sv
verification/top_board_chk.sv
verification/tb_top_board.sv

/* verification/tb_top_board.sv */
module tb_top_board;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int nb_addr      = 7;
    localparam int clks_per_bit = 8;
    localparam int wait_limit   = 2000;           // clocks allowed per wait loop
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic clock = 1'b0;
    logic reset;
    logic receiving;
    logic debug_out;
    logic state_idle;
    logic state_receive_instruction;
    logic state_run;
    logic state_tx_data_to_computer;
    logic read_rx;

    logic [31:0] lfsr;
    logic [31:0] prog [$];                        // program words, halt last
    logic [31:0] exp_regs [32];
    logic [31:0] exp_mem [2**nb_addr];
    int          exp_pc;
    int          rx_pulses = 0;
    bit          verdict_given = 1'b0;

    top_board #(.nb_addr(nb_addr), .clks_per_bit(clks_per_bit)) DUT (
        .clock(clock), .reset(reset), .receiving(receiving), .debug_out(debug_out),
        .state_idle(state_idle), .state_receive_instruction(state_receive_instruction),
        .state_run(state_run), .state_tx_data_to_computer(state_tx_data_to_computer),
        .read_rx(read_rx)
    );

    always #20 clock = ~clock;

    always @(negedge clock) begin
        if (read_rx === 1'b1) rx_pulses++;
    end

    task automatic fail_now();
        verdict_given = 1'b1;
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("[ERROR] time %0t %s got %0h expected %0h", $time, name, got, expected);
        fail_now();
    endtask

    task automatic report_timeout(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        fail_now();
    endtask

    // galois step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rd,
                                               input logic [4:0] rs, input logic [4:0] rt);
        return {mips_pkg::op_rtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rt,
                                               input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [2:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        kind = 3'(take_bits(3));
        rs   = 5'(take_bits(5));
        rt   = 5'(take_bits(5));
        rd   = 5'(take_bits(5));
        imm  = 16'(take_bits(16));
        case (kind)
            3'd0: return rtype_word(mips_pkg::fn_addu, rd, rs, rt);
            3'd1: return rtype_word(mips_pkg::fn_subu, rd, rs, rt);
            3'd2: return rtype_word(mips_pkg::fn_and, rd, rs, rt);
            3'd3: return rtype_word(mips_pkg::fn_or, rd, rs, rt);
            // base r0 and a small offset keep memory traffic inside the dump
            3'd4: return itype_word(mips_pkg::op_lw, rt, 5'd0, {12'd0, imm[3:0]});
            3'd5: return itype_word(mips_pkg::op_sw, rt, 5'd0, {12'd0, imm[3:0]});
            default: return itype_word(mips_pkg::op_addi, rt, rs, imm);
        endcase
    endfunction

    task automatic drive_byte(input logic [7:0] value);
        logic [9:0] frame;
        frame = {1'b1, value, 1'b0};              // stop, data, start
        for (int b = 0; b < 10; b++) begin
            @(posedge clock);
            receiving <= frame[b];
            repeat (clks_per_bit - 1) @(posedge clock);
        end
    endtask

    task automatic load_program();
        int start;
        int guard;
        start = rx_pulses;
        guard = 0;
        foreach (prog[i]) begin
            for (int k = 0; k < 4; k++) drive_byte(prog[i][8*k +: 8]);  // lsb first
        end
        while (rx_pulses - start < 4 * prog.size()) begin
            if (guard == wait_limit) report_timeout("read_rx pulse of the last byte");
            guard++;
            @(negedge clock);
        end
        guard = 0;
        while (state_receive_instruction !== 1'b0) begin  // last pulse is counted by then
            if (guard == wait_limit) report_timeout("the debug unit to finish loading");
            guard++;
            @(negedge clock);
        end
        assert (rx_pulses - start == 4 * prog.size())
            else report_mismatch("read_rx pulses", rx_pulses - start, 4 * prog.size());
    endtask

    task automatic capture_byte(output logic [7:0] value);
        int guard;
        guard = 0;
        value = '0;
        @(negedge clock);
        while (debug_out !== 1'b0) begin
            if (guard == wait_limit) report_timeout("a start bit on debug_out");
            guard++;
            @(negedge clock);
        end
        repeat (clks_per_bit / 2) @(negedge clock);  // middle of the start bit
        for (int b = 0; b < 8; b++) begin
            repeat (clks_per_bit) @(negedge clock);
            value[b] = debug_out;
        end
        repeat (clks_per_bit) @(negedge clock);
        if (debug_out !== 1'b1) report_mismatch("debug_out stop bit", 32'(debug_out), 32'd1);
    endtask

    // ISA reference, state carries over from one program to the next
    task automatic model_program();
        logic [31:0]        w;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        imm;
        logic [31:0]        value;
        logic [4:0]         dest;
        logic [nb_addr-1:0] idx;
        bit                 write;
        exp_pc = -1;
        for (int i = 0; i < prog.size() && exp_pc < 0; i++) begin
            w     = prog[i];
            a     = exp_regs[w[25:21]];
            b     = exp_regs[w[20:16]];
            imm   = {{16{w[15]}}, w[15:0]};
            idx   = nb_addr'(a + imm);            // word index wraps
            dest  = w[20:16];
            value = a + imm;
            write = 1'b0;
            case (w[31:26])
                mips_pkg::op_halt: exp_pc = i;
                mips_pkg::op_addi: write = 1'b1;
                mips_pkg::op_lw: begin
                    value = exp_mem[idx];
                    write = 1'b1;
                end
                mips_pkg::op_sw: exp_mem[idx] = b;
                mips_pkg::op_rtype: begin
                    dest  = w[15:11];
                    write = 1'b1;
                    case (w[5:0])
                        mips_pkg::fn_addu: value = a + b;
                        mips_pkg::fn_subu: value = a - b;
                        mips_pkg::fn_and:  value = a & b;
                        default:           value = a | b;
                    endcase
                end
                default: ;
            endcase
            if (write && dest != 5'd0) exp_regs[dest] = value;  // r0 stays zero
        end
    endtask

    task automatic check_dump();
        logic [31:0] words [$];
        logic [7:0]  got;
        logic [7:0]  expected;
        words.push_back(32'(exp_pc));
        foreach (exp_regs[r]) words.push_back(exp_regs[r]);
        for (int m = 0; m < mips_pkg::n_mem_dump; m++) words.push_back(exp_mem[m]);
        foreach (words[w]) begin
            for (int k = 0; k < 4 && (w > 0 || k == 0); k++) begin  // pc is one byte
                expected = words[w][8*k +: 8];
                capture_byte(got);
                assert (got == expected)
                    else report_mismatch($sformatf("debug_out word %0d byte %0d", w, k),
                                         32'(got), 32'(expected));
            end
        end
    endtask

    task automatic wait_for_idle();
        int guard;
        guard = 0;
        while (state_idle !== 1'b1) begin
            if (guard == wait_limit) report_timeout("state_idle after the dump");
            guard++;
            @(negedge clock);
        end
    endtask

    initial begin
        reset     = 1'b1;
        receiving = 1'b1;
        lfsr      = 32'h26e6_4582;
        foreach (exp_regs[r]) exp_regs[r] = '0;
        foreach (exp_mem[m]) exp_mem[m] = '0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;

        prog.push_back(itype_word(mips_pkg::op_addi, 5'd1, 5'd0, 16'd25));
        prog.push_back(itype_word(mips_pkg::op_addi, 5'd2, 5'd0, 16'hfffa));  // -6
        prog.push_back(rtype_word(mips_pkg::fn_addu, 5'd3, 5'd1, 5'd2));
        prog.push_back(rtype_word(mips_pkg::fn_subu, 5'd4, 5'd1, 5'd2));
        prog.push_back(rtype_word(mips_pkg::fn_and, 5'd5, 5'd1, 5'd2));
        prog.push_back(rtype_word(mips_pkg::fn_or, 5'd6, 5'd1, 5'd2));
        prog.push_back(itype_word(mips_pkg::op_sw, 5'd3, 5'd0, 16'd2));
        prog.push_back(itype_word(mips_pkg::op_lw, 5'd7, 5'd0, 16'd2));
        prog.push_back(itype_word(mips_pkg::op_addi, 5'd0, 5'd1, 16'd100));   // r0 write
        prog.push_back(rtype_word(mips_pkg::fn_addu, 5'd8, 5'd0, 5'd4));
        prog.push_back(itype_word(mips_pkg::op_sw, 5'd6, 5'd1, 16'hffec));    // 25 - 20
        prog.push_back(itype_word(mips_pkg::op_lw, 5'd9, 5'd0, 16'd5));
        prog.push_back(mips_pkg::halt_word);
        load_program();
        model_program();
        check_dump();
        wait_for_idle();

        // second load from idle with a random program
        prog.delete();
        for (int i = 0; i < 20; i++) prog.push_back(random_instr());
        prog.push_back(mips_pkg::halt_word);
        load_program();
        model_program();
        check_dump();
        wait_for_idle();

        verdict_given = 1'b1;
        if (DUT.u_chk.fail_count == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("%0d bound assertion failures", DUT.u_chk.fail_count);
            fail_now();
        end
    end

    // a bound assertion can end the run before the main sequence does
    final begin
        if (!verdict_given && DUT.u_chk.fail_count != 0) $display("Simulation failed");
    end

endmodule

/* verification/top_board_chk.sv */
module top_board_chk (
    input logic clock,
    input logic reset,
    input logic debug_out,
    input logic state_idle,
    input logic state_receive_instruction,
    input logic state_run,
    input logic state_tx_data_to_computer,
    input logic read_rx
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // failed assertions so far

    reset_idle: assert property (@(posedge clock) reset |=> (state_idle && debug_out))
        else begin
            fail_count++;
            $error("state_idle or debug_out not high after reset");
        end

    one_state: assert property (@(posedge clock) disable iff (reset)
        $onehot({state_idle, state_receive_instruction, state_run,
                 state_tx_data_to_computer}))
        else begin
            fail_count++;
            $error("state flags are not one-hot");
        end

    // dump only follows a run
    send_after_run: assert property (@(posedge clock) disable iff (reset)
        $rose(state_tx_data_to_computer) |-> $past(state_run))
        else begin
            fail_count++;
            $error("dump started without a run before it");
        end

    send_until_idle: assert property (@(posedge clock) disable iff (reset)
        state_tx_data_to_computer |=> (state_tx_data_to_computer || state_idle))
        else begin
            fail_count++;
            $error("dump left for a state other than idle");
        end

    line_quiet: assert property (@(posedge clock) disable iff (reset)
        !debug_out |-> state_tx_data_to_computer)
        else begin
            fail_count++;
            $error("debug_out low outside the dump");
        end

    rx_strobe: assert property (@(posedge clock) disable iff (reset) read_rx |=> !read_rx)
        else begin
            fail_count++;
            $error("read_rx longer than one clock");
        end

endmodule

bind top_board top_board_chk u_chk (
    .clock(clock), .reset(reset), .debug_out(debug_out),
    .state_idle(state_idle), .state_receive_instruction(state_receive_instruction),
    .state_run(state_run), .state_tx_data_to_computer(state_tx_data_to_computer),
    .read_rx(read_rx)
);

/* verilog/debug_unit.sv */
module debug_unit #(
    parameter int nb_addr = 7
) (
    input  logic                         clock,
    input  logic                         reset,
    input  logic [7:0]                   rx_data,
    input  logic                         rx_valid,
    input  logic                         tx_busy,
    input  logic                         halted,
    input  logic [nb_addr-1:0]           pc,
    input  logic [mips_pkg::nb_data-1:0] reg_data,
    input  logic [mips_pkg::nb_data-1:0] mem_data,
    output logic [7:0]                   tx_data,
    output logic                         tx_start,
    output logic                         imem_we,
    output logic [nb_addr-1:0]           imem_waddr,
    output logic [mips_pkg::nb_data-1:0] imem_wdata,
    output logic                         run_enable,
    output logic [mips_pkg::nb_reg-1:0]  reg_addr,
    output logic [nb_addr-1:0]           mem_addr,
    output logic                         state_idle,
    output logic                         state_receive_instruction,
    output logic                         state_run,
    output logic                         state_tx_data_to_computer
);
    // pc, then the register file, then the first data words
    localparam int n_dump_words = 1 + mips_pkg::n_register + mips_pkg::n_mem_dump;
    localparam int wc_w = $clog2(n_dump_words);
    localparam logic [wc_w-1:0] last_word      = wc_w'(n_dump_words - 1);
    localparam logic [wc_w-1:0] first_mem_word = wc_w'(1 + mips_pkg::n_register);

    mips_pkg::debug_state_t       state;
    logic [1:0]                   rx_count;   // bytes of the current word so far
    logic [mips_pkg::nb_data-1:0] word_buf;
    logic [mips_pkg::nb_data-1:0] rx_word;
    logic [wc_w-1:0]              word_count;
    logic [1:0]                   byte_count;
    logic                         last_sent;
    logic [wc_w-1:0]              reg_index;
    logic [wc_w-1:0]              mem_index;
    logic [mips_pkg::nb_data-1:0] send_word;
    logic                         tx_ready;

    assign rx_word   = {rx_data, word_buf[mips_pkg::nb_data-1:8]};  // lsb first on the line
    assign reg_index = word_count - 1'b1;
    assign mem_index = word_count - first_mem_word;
    assign reg_addr  = reg_index[mips_pkg::nb_reg-1:0];
    assign mem_addr  = nb_addr'(mem_index);
    assign tx_ready  = !tx_busy && !tx_start;  // busy lags the start strobe by a cycle

    always_comb begin
        if (word_count == '0) send_word = mips_pkg::nb_data'(pc);
        else if (word_count < first_mem_word) send_word = reg_data;
        else send_word = mem_data;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= mips_pkg::st_idle;
            rx_count   <= '0;
            imem_waddr <= '0;
            imem_we    <= 1'b0;
            tx_start   <= 1'b0;
            word_count <= '0;
            byte_count <= '0;
            last_sent  <= 1'b0;
        end else begin
            imem_we  <= 1'b0;
            tx_start <= 1'b0;
            case (state)
                mips_pkg::st_idle: begin
                    imem_waddr <= '0;
                    if (rx_valid) begin
                        rx_count <= 2'd1;
                        state    <= mips_pkg::st_receive_instruction;
                    end
                end
                mips_pkg::st_receive_instruction: begin
                    if (rx_valid) begin
                        rx_count <= rx_count + 1'b1;
                        if (rx_count == 2'd3) imem_we <= 1'b1;
                    end
                    if (imem_we) begin
                        imem_waddr <= imem_waddr + 1'b1;
                        if (imem_wdata == mips_pkg::halt_word) state <= mips_pkg::st_run;
                    end
                end
                mips_pkg::st_run: begin
                    if (halted) begin
                        word_count <= '0;
                        byte_count <= '0;
                        last_sent  <= 1'b0;
                        state      <= mips_pkg::st_send_data;
                    end
                end
                default: begin
                    if (last_sent) begin
                        if (tx_ready) state <= mips_pkg::st_idle;  // last frame done
                    end else if (tx_ready) begin
                        tx_start <= 1'b1;
                        // pc goes out as a single byte
                        if (word_count == '0 || byte_count == 2'd3) begin
                            byte_count <= '0;
                            word_count <= word_count + 1'b1;
                            if (word_count == last_word) last_sent <= 1'b1;
                        end else begin
                            byte_count <= byte_count + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (rx_valid) word_buf <= rx_word;
        if (state == mips_pkg::st_receive_instruction && rx_valid && rx_count == 2'd3) begin
            imem_wdata <= rx_word;
        end
        if (state == mips_pkg::st_send_data && !last_sent && tx_ready) begin
            tx_data <= send_word[8*byte_count +: 8];
        end
    end

    assign run_enable                = (state == mips_pkg::st_run);
    assign state_idle                = (state == mips_pkg::st_idle);
    assign state_receive_instruction = (state == mips_pkg::st_receive_instruction);
    assign state_run                 = (state == mips_pkg::st_run);
    assign state_tx_data_to_computer = (state == mips_pkg::st_send_data);

endmodule

/* verilog/mips_core.sv */
module mips_core #(
    parameter int nb_addr = 7
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          run_enable,
    input  logic                          imem_we,
    input  logic [nb_addr-1:0]            imem_waddr,
    input  logic [mips_pkg::nb_data-1:0]  imem_wdata,
    input  logic [mips_pkg::nb_reg-1:0]   reg_addr,
    input  logic [nb_addr-1:0]            mem_addr,
    output logic [mips_pkg::nb_data-1:0]  reg_data,
    output logic [mips_pkg::nb_data-1:0]  mem_data,
    output logic [nb_addr-1:0]            pc,
    output logic                          halted
);
    localparam int n_words = 2 ** nb_addr;
    localparam int n_regs  = 2 ** mips_pkg::nb_reg;

    logic [mips_pkg::nb_data-1:0] imem [n_words];
    logic [mips_pkg::nb_data-1:0] dmem [n_words];
    logic [mips_pkg::nb_data-1:0] regs [n_regs];

    logic [mips_pkg::nb_data-1:0] instr;
    mips_pkg::opcode_t            opcode;
    mips_pkg::funct_t             funct;
    logic [mips_pkg::nb_reg-1:0]  rs;
    logic [mips_pkg::nb_reg-1:0]  rt;
    logic [mips_pkg::nb_reg-1:0]  rd;
    logic [mips_pkg::nb_reg-1:0]  dest;
    logic [mips_pkg::nb_data-1:0] rs_val;
    logic [mips_pkg::nb_data-1:0] rt_val;
    logic [mips_pkg::nb_data-1:0] imm_ext;
    logic [mips_pkg::nb_data-1:0] eff_addr;
    logic [mips_pkg::nb_data-1:0] result;
    logic                         reg_we;
    logic                         mem_we;
    logic                         step;

    assign instr    = imem[pc];
    assign opcode   = mips_pkg::opcode_t'(instr[31:26]);
    assign funct    = mips_pkg::funct_t'(instr[5:0]);
    assign rs       = instr[25:21];
    assign rt       = instr[20:16];
    assign rd       = instr[15:11];
    assign imm_ext  = {{16{instr[15]}}, instr[15:0]};
    assign rs_val   = (rs == '0) ? '0 : regs[rs];  // r0 reads zero
    assign rt_val   = (rt == '0) ? '0 : regs[rt];
    assign eff_addr = rs_val + imm_ext;            // addi sum and load/store word index
    assign step     = run_enable && !halted;

    always_comb begin
        result = '0;
        dest   = rd;
        reg_we = 1'b0;
        mem_we = 1'b0;
        case (opcode)
            mips_pkg::op_rtype: begin
                reg_we = 1'b1;
                case (funct)
                    mips_pkg::fn_addu: result = rs_val + rt_val;
                    mips_pkg::fn_subu: result = rs_val - rt_val;
                    mips_pkg::fn_and:  result = rs_val & rt_val;
                    mips_pkg::fn_or:   result = rs_val | rt_val;
                    default:           reg_we = 1'b0;
                endcase
            end
            mips_pkg::op_addi: begin
                result = eff_addr;
                dest   = rt;
                reg_we = 1'b1;
            end
            mips_pkg::op_lw: begin
                result = dmem[eff_addr[nb_addr-1:0]];
                dest   = rt;
                reg_we = 1'b1;
            end
            mips_pkg::op_sw: mem_we = 1'b1;
            default: ;  // halt and unknown opcodes write nothing
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc     <= '0;
            halted <= 1'b0;
        end else if (imem_we) begin
            pc     <= '0;  // a new program restarts from address 0
            halted <= 1'b0;
        end else if (step) begin
            if (opcode == mips_pkg::op_halt) halted <= 1'b1;
            else pc <= pc + 1'b1;
        end
    end

    // register file and data memory start cleared for a known first dump
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < n_regs; i++) begin
                regs[i] <= '0;
            end
            for (int j = 0; j < n_words; j++) begin
                dmem[j] <= '0;
            end
        end else if (step) begin
            if (reg_we) regs[dest] <= result;
            if (mem_we) dmem[eff_addr[nb_addr-1:0]] <= rt_val;
        end
    end

    always_ff @(posedge clock) begin
        if (imem_we) imem[imem_waddr] <= imem_wdata;
    end

    assign reg_data = (reg_addr == '0) ? '0 : regs[reg_addr];
    assign mem_data = dmem[mem_addr];

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

    localparam int nb_data    = 32;  // data and instruction width
    localparam int nb_reg     = 5;   // register address width
    localparam int n_register = 32;
    localparam int n_mem_dump = 16;  // data words sent back after a run

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        op_rtype = 6'h00,
        op_addi  = 6'h08,
        op_lw    = 6'h23,
        op_sw    = 6'h2b,
        op_halt  = 6'h3f
    } opcode_t;

    // function field of r-type, instr[5:0]
    typedef enum logic [5:0] {
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25
    } funct_t;

    // end of program marker, opcode only
    localparam logic [nb_data-1:0] halt_word = {op_halt, 26'd0};

    typedef enum logic [1:0] {
        st_idle,
        st_receive_instruction,
        st_run,
        st_send_data
    } debug_state_t;

endpackage

/* verilog/top_board.sv */
module top_board #(
    parameter int nb_addr      = 7,
    parameter int clks_per_bit = 868
) (
    input  logic clock,
    input  logic reset,
    input  logic receiving,
    output logic debug_out,
    output logic state_idle,
    output logic state_receive_instruction,
    output logic state_run,
    output logic state_tx_data_to_computer,
    output logic read_rx
);
    logic [7:0]                   rx_data;
    logic                         rx_valid;
    logic [7:0]                   tx_data;
    logic                         tx_start;
    logic                         tx_busy;
    logic                         imem_we;
    logic [nb_addr-1:0]           imem_waddr;
    logic [mips_pkg::nb_data-1:0] imem_wdata;
    logic                         run_enable;
    logic [mips_pkg::nb_reg-1:0]  reg_addr;
    logic [nb_addr-1:0]           mem_addr;
    logic [mips_pkg::nb_data-1:0] reg_data;
    logic [mips_pkg::nb_data-1:0] mem_data;
    logic [nb_addr-1:0]           pc;
    logic                         halted;

    uart_rx #(.clks_per_bit(clks_per_bit)) u_rx (
        .clock(clock), .reset(reset), .rx(receiving),
        .rx_data(rx_data), .rx_valid(rx_valid)
    );

    uart_tx #(.clks_per_bit(clks_per_bit)) u_tx (
        .clock(clock), .reset(reset), .tx_data(tx_data), .tx_start(tx_start),
        .tx(debug_out), .tx_busy(tx_busy)
    );

    debug_unit #(.nb_addr(nb_addr)) u_debug (
        .clock(clock), .reset(reset),
        .rx_data(rx_data), .rx_valid(rx_valid), .tx_busy(tx_busy),
        .halted(halted), .pc(pc), .reg_data(reg_data), .mem_data(mem_data),
        .tx_data(tx_data), .tx_start(tx_start),
        .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .run_enable(run_enable), .reg_addr(reg_addr), .mem_addr(mem_addr),
        .state_idle(state_idle), .state_receive_instruction(state_receive_instruction),
        .state_run(state_run), .state_tx_data_to_computer(state_tx_data_to_computer)
    );

    mips_core #(.nb_addr(nb_addr)) u_core (
        .clock(clock), .reset(reset), .run_enable(run_enable),
        .imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .reg_addr(reg_addr), .mem_addr(mem_addr),
        .reg_data(reg_data), .mem_data(mem_data), .pc(pc), .halted(halted)
    );

    assign read_rx = rx_valid;  // board probe for received bytes

endmodule

/* verilog/uart_rx.sv */
module uart_rx #(
    parameter int clks_per_bit = 868
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);
    localparam int cnt_w = $clog2(clks_per_bit) + 1;
    localparam logic [cnt_w-1:0] full_count = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_count = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {rx_idle, rx_start, rx_bits, rx_stop} rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] clk_count;
    logic [2:0]       bit_index;
    logic [7:0]       shift;

    // two flops against metastability, idle level is high
    always_ff @(posedge clock) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= rx_idle;
            clk_count <= '0;
            bit_index <= '0;
            rx_valid  <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_idle: begin
                    clk_count <= '0;
                    bit_index <= '0;
                    if (!rx_sync) state <= rx_start;  // falling start edge
                end
                rx_start: begin
                    if (clk_count == half_count) begin
                        clk_count <= '0;
                        state     <= rx_sync ? rx_idle : rx_bits;  // glitch if high again
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                rx_bits: begin
                    if (clk_count == full_count) begin
                        clk_count <= '0;
                        bit_index <= bit_index + 1'b1;
                        if (bit_index == 3'd7) state <= rx_stop;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
                default: begin
                    if (clk_count == full_count) begin
                        rx_valid <= rx_sync;  // drop frames without a stop bit
                        state    <= rx_idle;
                    end else begin
                        clk_count <= clk_count + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first, so shift in from the top
    always_ff @(posedge clock) begin
        if (state == rx_bits && clk_count == full_count) shift <= {rx_sync, shift[7:1]};
    end

    assign rx_data = shift;

endmodule

/* verilog/uart_tx.sv */
module uart_tx #(
    parameter int clks_per_bit = 868
) (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy
);
    localparam int cnt_w = $clog2(clks_per_bit) + 1;
    localparam logic [cnt_w-1:0] full_count = cnt_w'(clks_per_bit - 1);

    logic [9:0]       shift;      // stop, data, start
    logic [cnt_w-1:0] clk_count;
    logic [3:0]       bit_count;

    always_ff @(posedge clock) begin
        if (reset) begin
            tx_busy   <= 1'b0;
            clk_count <= '0;
            bit_count <= '0;
        end else if (!tx_busy) begin
            clk_count <= '0;
            bit_count <= '0;
            if (tx_start) tx_busy <= 1'b1;
        end else if (clk_count == full_count) begin
            clk_count <= '0;
            bit_count <= bit_count + 1'b1;
            if (bit_count == 4'd9) tx_busy <= 1'b0;  // end of stop bit
        end else begin
            clk_count <= clk_count + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!tx_busy && tx_start) begin
            shift <= {1'b1, tx_data, 1'b0};
        end else if (tx_busy && clk_count == full_count) begin
            shift <= {1'b1, shift[9:1]};
        end
    end

    // line idles high between frames
    assign tx = tx_busy ? shift[0] : 1'b1;

endmodule
